// File: verilog/sobel_pkg.sv
`default_nettype none

package sobel_pkg;

  localparam int unsigned IMG_COLS = 8;  // frame width in pixels
  localparam int unsigned IMG_ROWS = 6;  // frame height in pixels
  localparam int unsigned COL_AW   = $clog2(IMG_COLS);  // line buffer address width
  localparam int unsigned WIN_TAPS = 9;  // 3x3 window, row-major
  localparam int unsigned MAG_MAX  = 255;  // magnitude saturation

  typedef logic [7:0] pix_t;  // greyscale pixel
  typedef logic [7:0] mag_t;  // clipped gradient magnitude
  typedef logic [3:0] coord_t;  // column or row index

  localparam coord_t COL_LAST = coord_t'(IMG_COLS - 1);
  localparam coord_t ROW_LAST = coord_t'(IMG_ROWS - 1);
  localparam coord_t WIN_EDGE = coord_t'(2);  // first index that closes a window

  // input side, ING_ACK is the single step cycle
  typedef enum logic [1:0] {
    ING_IDLE,
    ING_ACK,
    ING_WAIT_LOW
  } ing_state_t;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_WAIT_LOW
  } out_state_t;

endpackage

`default_nettype wire

// File: verilog/tap_if.sv
`timescale 1ns/100ps
`default_nettype none

// one accepted pixel column, oldest row on top
interface tap_if;
  logic            step;  // one strobe per accepted pixel
  sobel_pkg::pix_t top;  // two rows above
  sobel_pkg::pix_t mid;  // one row above
  sobel_pkg::pix_t bot;  // current pixel

  modport prod (
    output step,
    output top,
    output mid,
    output bot
  );

  modport cons (
    input step,
    input top,
    input mid,
    input bot
  );
endinterface

`default_nettype wire

// File: verilog/window_if.sv
`timescale 1ns/100ps
`default_nettype none

interface window_if;
  logic            win_valid;  // one-cycle strobe per complete window
  sobel_pkg::pix_t win [sobel_pkg::WIN_TAPS];  // 0 is top-left, row-major

  modport prod (
    output win_valid,
    output win
  );

  modport cons (
    input win_valid,
    input win
  );
endinterface

`default_nettype wire

// File: verilog/pixel_ingress.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_ingress (
  input  logic            clk,
  input  logic            rst_n,
  input  sobel_pkg::pix_t pix_i,
  input  logic            req_i,
  input  logic            hold_i,
  output logic            ack_o,
  tap_if.prod             tap
);

  sobel_pkg::ing_state_t         state;
  sobel_pkg::coord_t             col;
  logic [sobel_pkg::COL_AW-1:0]  addr;
  logic                          accept;

  // line_two holds the row two above, line_one the row just above
  sobel_pkg::pix_t line_two [sobel_pkg::IMG_COLS];
  sobel_pkg::pix_t line_one [sobel_pkg::IMG_COLS];

  assign addr   = col[sobel_pkg::COL_AW-1:0];
  assign accept = (state == sobel_pkg::ING_IDLE) && req_i && !hold_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sobel_pkg::ING_IDLE;
    end else begin
      case (state)
        sobel_pkg::ING_IDLE: begin
          if (accept) begin
            state <= sobel_pkg::ING_ACK;
          end
        end
        sobel_pkg::ING_ACK: begin
          state <= sobel_pkg::ING_WAIT_LOW;  // taps go out this cycle
        end
        sobel_pkg::ING_WAIT_LOW: begin
          if (!req_i) begin
            state <= sobel_pkg::ING_IDLE;
          end
        end
        default: begin
          state <= sobel_pkg::ING_IDLE;
        end
      endcase
    end
  end

  // line memories and the column they are addressed by
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
      for (int i = 0; i < int'(sobel_pkg::IMG_COLS); i++) begin
        line_two[i] <= '0;
        line_one[i] <= '0;
      end
    end else if (accept) begin
      line_two[addr] <= line_one[addr];  // row moves up by one
      line_one[addr] <= pix_i;
      if (col == sobel_pkg::COL_LAST) begin
        col <= '0;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tap.top <= line_two[addr];
      tap.mid <= line_one[addr];
      tap.bot <= pix_i;
    end
  end

  assign tap.step = (state == sobel_pkg::ING_ACK);
  assign ack_o    = (state != sobel_pkg::ING_IDLE);  // high until req_i is seen low

endmodule

`default_nettype wire

// File: verilog/window_buffer_3x3.sv
`timescale 1ns/100ps
`default_nettype none

module window_buffer_3x3 (
  input  logic clk,
  input  logic rst_n,
  tap_if.cons  tap,
  window_if.prod win
);

  // win_sr[row][age], age 0 is the newest column
  sobel_pkg::pix_t   win_sr [3][3];
  sobel_pkg::pix_t   col_in [3];
  sobel_pkg::coord_t col;
  sobel_pkg::coord_t row;
  logic              closes;

  assign col_in[0] = tap.top;
  assign col_in[1] = tap.mid;
  assign col_in[2] = tap.bot;

  // pixel at column >= 2 and row >= 2 fills the last window slot
  assign closes = (col >= sobel_pkg::WIN_EDGE) && (row >= sobel_pkg::WIN_EDGE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < 3; r++) begin
        for (int a = 0; a < 3; a++) begin
          win_sr[r][a] <= '0;
        end
      end
    end else if (tap.step) begin
      for (int r = 0; r < 3; r++) begin
        win_sr[r][0] <= col_in[r];
        win_sr[r][1] <= win_sr[r][0];
        win_sr[r][2] <= win_sr[r][1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col           <= '0;
      row           <= '0;
      win.win_valid <= 1'b0;
    end else begin
      win.win_valid <= tap.step && closes;
      if (tap.step) begin
        if (col == sobel_pkg::COL_LAST) begin
          col <= '0;
          if (row == sobel_pkg::ROW_LAST) begin
            row <= '0;  // frame end
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          col <= col + 1'b1;
        end
      end
    end
  end

  // oldest column is the leftmost one
  for (genvar r = 0; r < 3; r++) begin : g_row
    for (genvar c = 0; c < 3; c++) begin : g_col
      assign win.win[3*r + c] = win_sr[r][2-c];
    end
  end

endmodule

`default_nettype wire

// File: verilog/sobel_stage.sv
`timescale 1ns/100ps
`default_nettype none

module sobel_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            out_ack_i,
  window_if.cons          win,
  output logic            hold_o,
  output sobel_pkg::mag_t mag_o,
  output logic            out_req_o
);

  typedef logic signed [11:0] grad_t;  // holds +-1020

  sobel_pkg::out_state_t state;
  grad_t                 gx;
  grad_t                 gy;
  logic [11:0]           abs_x;
  logic [11:0]           abs_y;
  logic [11:0]           sum;
  sobel_pkg::mag_t       mag_next;
  logic                  take;

  function automatic grad_t ext(input sobel_pkg::pix_t p);
    return grad_t'({4'b0000, p});
  endfunction

  always_comb begin
    // right column minus left column
    gx = ext(win.win[2]) + (ext(win.win[5]) <<< 1) + ext(win.win[8])
       - ext(win.win[0]) - (ext(win.win[3]) <<< 1) - ext(win.win[6]);
    // bottom row minus top row
    gy = ext(win.win[6]) + (ext(win.win[7]) <<< 1) + ext(win.win[8])
       - ext(win.win[0]) - (ext(win.win[1]) <<< 1) - ext(win.win[2]);
    abs_x = gx[11] ? 12'(-gx) : 12'(gx);
    abs_y = gy[11] ? 12'(-gy) : 12'(gy);
    sum   = abs_x + abs_y;
    if (sum > 12'(sobel_pkg::MAG_MAX)) begin
      mag_next = sobel_pkg::mag_t'(sobel_pkg::MAG_MAX);
    end else begin
      mag_next = sum[7:0];
    end
  end

  assign take = (state == sobel_pkg::OUT_IDLE) && win.win_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sobel_pkg::OUT_IDLE;
    end else begin
      case (state)
        sobel_pkg::OUT_IDLE: begin
          if (take) begin
            state <= sobel_pkg::OUT_REQ;
          end
        end
        sobel_pkg::OUT_REQ: begin
          if (out_ack_i) begin
            state <= sobel_pkg::OUT_WAIT_LOW;  // drop req
          end
        end
        sobel_pkg::OUT_WAIT_LOW: begin
          if (!out_ack_i) begin
            state <= sobel_pkg::OUT_IDLE;
          end
        end
        default: begin
          state <= sobel_pkg::OUT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      mag_o <= mag_next;
    end
  end

  assign out_req_o = (state == sobel_pkg::OUT_REQ);
  // covers the strobe cycle too, before the FSM has left idle
  assign hold_o    = win.win_valid || (state != sobel_pkg::OUT_IDLE);

endmodule

`default_nettype wire

// File: verilog/sobel_top.sv
`timescale 1ns/100ps
`default_nettype none

module sobel_top (
  input  logic            clk,
  input  logic            rst_n,
  input  sobel_pkg::pix_t pix_i,
  input  logic            req_i,
  output logic            ack_o,
  output sobel_pkg::mag_t mag_o,
  output logic            out_req_o,
  input  logic            out_ack_i
);

  logic hold;  // result stage busy, ingress must not accept

  tap_if    tap_bus ();
  window_if win_bus ();

  pixel_ingress u_ingress (
    .clk    (clk),
    .rst_n  (rst_n),
    .pix_i  (pix_i),
    .req_i  (req_i),
    .hold_i (hold),
    .ack_o  (ack_o),
    .tap    (tap_bus.prod)
  );

  window_buffer_3x3 u_window (
    .clk   (clk),
    .rst_n (rst_n),
    .tap   (tap_bus.cons),
    .win   (win_bus.prod)
  );

  sobel_stage u_sobel (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_ack_i (out_ack_i),
    .win       (win_bus.cons),
    .hold_o    (hold),
    .mag_o     (mag_o),
    .out_req_o (out_req_o)
  );

endmodule

`default_nettype wire

// File: test/sobel_props.sv
`timescale 1ns/100ps
`default_nettype none

// handshake rules seen at the ports of sobel_top
module sobel_props (
  input logic            clk,
  input logic            rst_n,
  input sobel_pkg::pix_t pix_i,
  input logic            req_i,
  input logic            ack_i,      // DUT ack_o
  input sobel_pkg::mag_t mag_i,      // DUT mag_o
  input logic            out_req_i,  // DUT out_req_o
  input logic            out_ack_i
);

  a_pix_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |=> (!req_i || $stable(pix_i)))
    else $error("pix_i changed while req_i was high");

  a_mag_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_req_i && !out_ack_i) |=> $stable(mag_i))
    else $error("mag_o changed before out_ack_i");

  // sampled one tick late, so req_i is checked in the accepting cycle
  a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose while req_i was low");

  a_out_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_req_i) |-> !$past(out_ack_i))
    else $error("out_req_o rose while out_ack_i was high");

endmodule

bind sobel_top sobel_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .pix_i     (pix_i),
  .req_i     (req_i),
  .ack_i     (ack_o),
  .mag_i     (mag_o),
  .out_req_i (out_req_o),
  .out_ack_i (out_ack_i)
);

`default_nettype wire

// File: test/tb_sobel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sobel;

  localparam int COLS      = int'(sobel_pkg::IMG_COLS);
  localparam int ROWS      = int'(sobel_pkg::IMG_ROWS);
  localparam int NUM_CASES = 6;
  localparam int SEED      = 31868;
  localparam int MAG_CLIP  = 255;

  // sobel kernels indexed [row][col]
  localparam int KX [3][3] = '{'{-1, 0, 1}, '{-2, 0, 2}, '{-1, 0, 1}};
  localparam int KY [3][3] = '{'{-1, -2, -1}, '{0, 0, 0}, '{1, 2, 1}};

  typedef enum int {PAT_CONST, PAT_VSTEP, PAT_HSTEP, PAT_RAMP, PAT_RANDOM} pat_t;

  typedef struct {
    pat_t kind;
    int   step;     // step height of the edge patterns
    int   frames;
    int   src_max;  // max source delay before req in cycles
    int   snk_max;  // max sink delay before ack
    int   exp_mag;  // magnitude known up front or -1
  } case_t;

  case_t cases [NUM_CASES] = '{
    '{PAT_CONST,  0,  1, 0, 0, 0},
    '{PAT_VSTEP,  40, 1, 2, 1, 160},
    '{PAT_HSTEP,  80, 1, 1, 2, 255},  // 4 * 80 clips
    '{PAT_RAMP,   0,  2, 0, 3, -1},
    '{PAT_RANDOM, 0,  3, 3, 5, -1},
    '{PAT_RANDOM, 0,  2, 0, 0, -1}
  };

  logic            clk;
  logic            rst_n;
  sobel_pkg::pix_t pix;
  logic            req;
  logic            ack;
  sobel_pkg::mag_t mag;
  logic            out_req;
  logic            out_ack;

  int              img [ROWS][COLS];  // frame being sent
  sobel_pkg::pix_t pix_q [$];
  int              exp_q [$];
  int              known_q [$];
  int              checks = 0;
  int              val_errors = 0;
  int              cycles = 0;
  int              cycle_limit = 0;
  int              ack_cycle = 0;
  logic            ack_prev = 1'b0;
  logic            oreq_prev = 1'b0;

  sobel_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_i     (pix),
    .req_i     (req),
    .ack_o     (ack),
    .mag_o     (mag),
    .out_req_o (out_req),
    .out_ack_i (out_ack)
  );

  task automatic check_val(input string name, input int actual, input int expected);
    checks++;
    if (actual != expected) begin
      val_errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  function automatic int timeout_cycles();
    int pixels;
    int src_w;
    int snk_w;
    pixels = 0;
    src_w  = 0;
    snk_w  = 0;
    foreach (cases[i]) begin
      pixels += cases[i].frames * COLS * ROWS;
      if (cases[i].src_max > src_w) src_w = cases[i].src_max;
      if (cases[i].snk_max > snk_w) snk_w = cases[i].snk_max;
    end
    return pixels * (src_w + snk_w + 8);
  endfunction

  // window with its bottom-right pixel at (r, c)
  function automatic int sobel_ref(input int r, input int c);
    int gx;
    int gy;
    int sum;
    gx = 0;
    gy = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        gx += KX[i][j] * img[r-2+i][c-2+j];
        gy += KY[i][j] * img[r-2+i][c-2+j];
      end
    end
    sum = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
    return (sum > MAG_CLIP) ? MAG_CLIP : sum;
  endfunction

  // table magnitude of the window ending at (r, c) or -1 without one
  function automatic int known_mag(input case_t tc, input int r, input int c);
    if (tc.exp_mag < 0) begin
      return -1;
    end else if (tc.kind == PAT_VSTEP) begin
      return (c >= COLS / 2 && c - 2 < COLS / 2) ? tc.exp_mag : 0;  // window spans the edge
    end else if (tc.kind == PAT_HSTEP) begin
      return (r >= ROWS / 2 && r - 2 < ROWS / 2) ? tc.exp_mag : 0;
    end else begin
      return tc.exp_mag;
    end
  endfunction

  task automatic build_frame(input case_t tc, input int f);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        case (tc.kind)
          PAT_CONST: img[r][c] = 100;
          PAT_VSTEP: img[r][c] = (c >= COLS / 2) ? 30 + tc.step : 30;
          PAT_HSTEP: img[r][c] = (r >= ROWS / 2) ? 30 + tc.step : 30;
          PAT_RAMP:  img[r][c] = r * 20 + c * 10 + f * 7;  // shifts per frame
          default:   img[r][c] = int'($urandom % 256);
        endcase
      end
    end
  endtask

  task automatic send_pixel(input sobel_pkg::pix_t p, input int max_delay);
    int unsigned d;
    d = $urandom % unsigned'(max_delay + 1);
    repeat (d) @(negedge clk);
    pix <= p;
    req <= 1'b1;
    @(negedge clk);
    while (!ack) @(negedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
  endtask

  task automatic receive_result(input int max_delay);
    int unsigned d;
    int          got;
    int          known;
    d = $urandom % unsigned'(max_delay + 1);
    @(negedge clk);
    while (!out_req) @(negedge clk);
    got   = int'(mag);
    known = known_q.pop_front();
    check_val("mag_o", got, exp_q.pop_front());
    if (known >= 0) begin
      check_val("mag_o (table value)", got, known);
    end
    repeat (d) @(negedge clk);
    out_ack <= 1'b1;
    @(negedge clk);
    while (out_req) @(negedge clk);
    out_ack <= 1'b0;
  endtask

  task automatic run_case(input case_t tc);
    int n_exp;
    n_exp = 0;
    for (int f = 0; f < tc.frames; f++) begin
      build_frame(tc, f);
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          pix_q.push_back(sobel_pkg::pix_t'(img[r][c]));
          if (r >= 2 && c >= 2) begin  // this pixel closes a window
            exp_q.push_back(sobel_ref(r, c));
            known_q.push_back(known_mag(tc, r, c));
            n_exp++;
          end
        end
      end
    end
    fork
      begin
        while (pix_q.size() > 0) send_pixel(pix_q.pop_front(), tc.src_max);
      end
      begin
        repeat (n_exp) receive_result(tc.snk_max);
      end
    join
    repeat (4) @(negedge clk);
    check_val("out_req_o after last result", int'(out_req), 0);  // no extra result
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_limit = timeout_cycles();
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout: run still busy after %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  // out_req_o must follow the ack_o rise of its pixel by two cycles
  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (ack && !ack_prev) begin
          ack_cycle = cycles;
        end
        if (out_req && !oreq_prev) begin
          check_val("out_req_o cycles after ack_o", cycles - ack_cycle, 2);
        end
      end
      ack_prev  = ack;
      oreq_prev = out_req;
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n   = 1'b0;
    pix     = '0;
    req     = 1'b0;
    out_ack = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_val("ack_o after reset", int'(ack), 0);
    check_val("out_req_o after reset", int'(out_req), 0);
    foreach (cases[i]) begin
      run_case(cases[i]);
    end
    $display("checks: %0d, value errors: %0d", checks, val_errors);
    if (val_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
verilog/sobel_pkg.sv
verilog/tap_if.sv
verilog/window_if.sv
verilog/pixel_ingress.sv
verilog/window_buffer_3x3.sv
verilog/sobel_stage.sv
verilog/sobel_top.sv
test/sobel_props.sv
test/tb_sobel.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module tb_sobel -f tb.f \
  > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_sobel > sim.log 2>&1 \
  || echo "simulation exited with a nonzero status" >> sim.log
cat sim.log

grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
